// File: zx_config.svh
//====================================================================
// Build constants for the paging and I/O port core
// Bank numbers count 16 KB units: RAM 0..63, ROM from the ROM base up
// Port match values cover only the address bits noted beside them
//====================================================================
`ifndef ZX_CONFIG_SVH
`define ZX_CONFIG_SVH

// Physical address split
`define ZX_BANK_W        7
`define ZX_OFFSET_W      14
`define ZX_ROM_BANK_BASE 64

// Read value of any port nobody answers
`define ZX_PORT_IDLE     8'hFF

// Low six address bits of the Kempston port
`define ZX_KEMPSTON_PORT 6'h1F
// Address bits 15..12 of port 1FFD
`define ZX_P1FFD_HIGH    4'b0001
// Address bits 15..12 of port EFF7
`define ZX_PEFF7_HIGH    4'b1110

// Values after reset
`define ZX_PAGE_RESET    8'h00
`define ZX_BORDER_RESET  3'd0

`endif

// File: zx_bus_pkg.sv
//====================================================================
// Types seen on the Wishbone side of the core
// Address is the 16-bit Z80 address, data is one byte
// The address tag tells memory cycles from I/O cycles
//====================================================================
`default_nettype none

package zx_bus_pkg;

	// CPU address and data byte
	typedef logic [15:0] bus_addr_t;
	typedef logic [7:0]  bus_data_t;

	// Carried on wb_tga_kind
	typedef enum logic {
		cycle_mem = 1'b0,
		cycle_io  = 1'b1
	} cycle_kind_e;

endpackage

`default_nettype wire

// File: zx_machine_pkg.sv
//====================================================================
// Machine-side types: model, joystick setup, paging registers and
// the translated physical address
// Joystick bit order matches the Kempston port, fire on bit 4
//====================================================================
`default_nettype none

`include "zx_config.svh"

package zx_machine_pkg;

	typedef enum logic [1:0] {
		zx48         = 2'd0,
		zx128        = 2'd1,
		pentagon1024 = 2'd2,
		plus3        = 2'd3
	} machine_model_e;

	// Same encoding as the joystick menu
	typedef enum logic [2:0] {
		kempston      = 3'd0,
		sinclair1     = 3'd1,
		sinclair2     = 3'd2,
		sinclair_both = 3'd3,
		cursor        = 3'd4
	} joy_mode_e;

	// Active high, one bit per switch
	typedef struct packed {
		logic fire;
		logic up;
		logic down;
		logic left;
		logic right;
	} joy_state_t;

	typedef struct packed {
		logic [`ZX_BANK_W-1:0]   bank;
		logic [`ZX_OFFSET_W-1:0] offset;
	} phys_addr_t;

	typedef struct packed {
		logic [7:0] p7ffd;
		logic [7:0] p1ffd;
		logic [7:0] peff7;
	} page_regs_t;

endpackage

`default_nettype wire

// File: zx_io_if.sv
//====================================================================
// Decoded I/O cycle from the bus slave to the port blocks
// io_wr and io_rd are one-clock strobes in the ack cycle
// addr and wdata follow the bus and are only meaningful with a strobe
//====================================================================
`timescale 1ns/1ns
`default_nettype none

interface zx_io_if;

	logic                  io_wr;
	logic                  io_rd;
	zx_bus_pkg::bus_addr_t addr;
	zx_bus_pkg::bus_data_t wdata;

	modport bus (
		output io_wr,
		output io_rd,
		output addr,
		output wdata
	);

	modport port (
		input io_wr,
		input io_rd,
		input addr,
		input wdata
	);

endinterface

`default_nettype wire

// File: zx_bus_slave.sv
//====================================================================
// Wishbone classic slave, fixed one-clock ack, no wait states
// Master must hold its signals until ack and drop stb for a clock
// I/O read data is valid only in the ack cycle
//====================================================================
`timescale 1ns/1ns
`default_nettype none

`include "zx_config.svh"

module zx_bus_slave (
	input  logic                    clk_sys,
	input  logic                    reset,
	input  logic                    wb_cyc,
	input  logic                    wb_stb,
	input  logic                    wb_we,
	input  zx_bus_pkg::cycle_kind_e wb_tga_kind,
	input  zx_bus_pkg::bus_addr_t   wb_adr,
	input  zx_bus_pkg::bus_data_t   wb_dat_w,
	output zx_bus_pkg::bus_data_t   wb_dat_r,
	output logic                    wb_ack,
	zx_io_if.bus                    io,
	input  logic                    page_hit,
	input  zx_bus_pkg::bus_data_t   page_rdata,
	input  logic                    ula_hit,
	input  zx_bus_pkg::bus_data_t   ula_rdata,
	output logic                    mem_cycle
);

	logic req;
	logic is_io;

	// New request, the held cycle after ack is not counted again
	assign req   = wb_cyc & wb_stb & ~wb_ack;
	assign is_io = (wb_tga_kind == zx_bus_pkg::cycle_io);

	//==================================================================
	// Ack and strobes
	//==================================================================
	always_ff @(posedge clk_sys) begin
		if (reset) begin
			wb_ack    <= 1'b0;
			io.io_wr  <= 1'b0;
			io.io_rd  <= 1'b0;
			mem_cycle <= 1'b0;
		end else begin
			wb_ack    <= req;
			io.io_wr  <= req & is_io & wb_we;
			io.io_rd  <= req & is_io & ~wb_we;
			mem_cycle <= req & ~is_io;
		end
	end

	// Master holds these through the ack cycle
	assign io.addr  = wb_adr;
	assign io.wdata = wb_dat_w;

	//==================================================================
	// Read data
	//==================================================================
	// Paging first, then ULA, then the idle value
	always_comb begin
		if (!is_io) begin
			wb_dat_r = '0;
		end else if (page_hit) begin
			wb_dat_r = page_rdata;
		end else if (ula_hit) begin
			wb_dat_r = ula_rdata;
		end else begin
			wb_dat_r = `ZX_PORT_IDLE;
		end
	end

endmodule

`default_nettype wire

// File: zx_paging.sv
//====================================================================
// Paging registers 7FFD, 1FFD, EFF7 and memory address translation
// Model is sampled while reset is high and held afterwards
// phys_addr follows the address in a memory ack cycle, then holds
// 1FFD special modes only reachable on +3
//====================================================================
`timescale 1ns/1ns
`default_nettype none

`include "zx_config.svh"

module zx_paging (
	input  logic                           clk_sys,
	input  logic                           reset,
	zx_io_if.port                          io,
	input  zx_machine_pkg::machine_model_e model,
	input  zx_bus_pkg::bus_addr_t          mem_addr,
	input  logic                           mem_cycle,
	output zx_machine_pkg::phys_addr_t     phys_addr,
	output logic                           mem_wr_ok,
	output logic                           page_hit,
	output zx_bus_pkg::bus_data_t          page_rdata
);

	localparam logic [`ZX_BANK_W-1:0] rom_base = `ZX_ROM_BANK_BASE;

	// All-RAM banks per slot, indexed by 1FFD bits 2..1
	localparam logic [2:0] special_map [4][4] = '{
		'{3'd0, 3'd1, 3'd2, 3'd3},
		'{3'd4, 3'd5, 3'd6, 3'd7},
		'{3'd4, 3'd5, 3'd6, 3'd3},
		'{3'd4, 3'd7, 3'd6, 3'd3}
	};

	zx_machine_pkg::machine_model_e model_q;
	zx_machine_pkg::page_regs_t     regs;
	logic [2:0]                     ext_bank;
	zx_bus_pkg::bus_addr_t          mem_addr_q;
	zx_bus_pkg::bus_addr_t          xlat_addr;
	logic                           is_48;
	logic                           is_p1024;
	logic                           is_plus3;
	logic                           locked;
	logic                           wr_7ffd;
	logic                           wr_1ffd;
	logic                           wr_eff7;
	logic                           sel_1ffd;
	logic [1:0]                     slot;
	logic [1:0]                     rom_num;
	logic                           special;
	logic [`ZX_BANK_W-1:0]          bank;

	assign is_48    = (model_q == zx_machine_pkg::zx48);
	assign is_p1024 = (model_q == zx_machine_pkg::pentagon1024);
	assign is_plus3 = (model_q == zx_machine_pkg::plus3);

	// In 1024K mode the lock bit is an extension bit instead
	assign locked = regs.p7ffd[5] & (~is_p1024 | regs.peff7[2]);

	//==================================================================
	// Port decode
	//==================================================================
	assign sel_1ffd = (io.addr[15:12] == `ZX_P1FFD_HIGH) & ~io.addr[1];
	assign wr_7ffd  = ~io.addr[15] & ~io.addr[1] & (io.addr[14] | ~is_plus3)
		& ~is_48 & ~locked;
	assign wr_1ffd  = sel_1ffd & is_plus3 & ~locked;
	assign wr_eff7  = (io.addr[15:12] == `ZX_PEFF7_HIGH) & ~io.addr[3] & is_p1024;

	// +3 reads back 7FFD through the 1FFD decode
	assign page_hit   = io.io_rd & sel_1ffd & is_plus3;
	assign page_rdata = regs.p7ffd;

	always_ff @(posedge clk_sys) begin
		if (reset) begin
			model_q    <= model;
			regs       <= {3{`ZX_PAGE_RESET}};
			ext_bank   <= '0;
			mem_addr_q <= '0;
		end else begin
			if (mem_cycle) begin
				mem_addr_q <= mem_addr;
			end
			if (io.io_wr) begin
				if (wr_7ffd) begin
					regs.p7ffd <= io.wdata;
					if (is_p1024 & ~regs.peff7[2]) begin
						ext_bank <= {io.wdata[5], io.wdata[7:6]};
					end
				end else if (wr_1ffd) begin
					regs.p1ffd <= io.wdata;
				end
				if (wr_eff7) begin
					regs.peff7 <= io.wdata;
				end
			end
		end
	end

	//==================================================================
	// Translation
	//==================================================================
	assign xlat_addr = mem_cycle ? mem_addr : mem_addr_q;
	assign slot      = xlat_addr[15:14];
	assign special   = regs.p1ffd[0];

	always_comb begin
		case (model_q)
			zx_machine_pkg::zx48:  rom_num = 2'd3;
			zx_machine_pkg::plus3: rom_num = {regs.p1ffd[2], regs.p7ffd[4]};
			default:               rom_num = {1'b0, regs.p7ffd[4]};
		endcase
	end

	always_comb begin
		if (special) begin
			bank = {{(`ZX_BANK_W-3){1'b0}}, special_map[regs.p1ffd[2:1]][slot]};
		end else begin
			case (slot)
				2'd0:    bank = rom_base + {{(`ZX_BANK_W-2){1'b0}}, rom_num};
				2'd1:    bank = `ZX_BANK_W'd5;
				2'd2:    bank = `ZX_BANK_W'd2;
				default: bank = {{(`ZX_BANK_W-6){1'b0}}, ext_bank, regs.p7ffd[2:0]};
			endcase
		end
	end

	assign phys_addr = {bank, xlat_addr[`ZX_OFFSET_W-1:0]};
	// ROM slot is the only read-only one
	assign mem_wr_ok = special | (slot != 2'd0);

endmodule

`default_nettype wire

// File: zx_ula_port.sv
//====================================================================
// ULA output port (border, EAR, MIC) and keyboard/Kempston reads
// Any even port is the ULA; key_cols is active low from the matrix
// Joystick keys are merged into the selected keyboard half-rows
//====================================================================
`timescale 1ns/1ns
`default_nettype none

`include "zx_config.svh"

module zx_ula_port (
	input  logic                       clk_sys,
	input  logic                       reset,
	zx_io_if.port                      io,
	input  zx_machine_pkg::joy_mode_e  joy_mode,
	input  zx_machine_pkg::joy_state_t joy_0,
	input  zx_machine_pkg::joy_state_t joy_1,
	input  logic [4:0]                 key_cols,
	output logic [2:0]                 border,
	output logic                       ear,
	output logic                       mic,
	output logic                       ula_hit,
	output zx_bus_pkg::bus_data_t      ula_rdata
);

	// Keys 0,9,8,7,6 on bits 0..4
	function automatic logic [4:0] sinclair1_keys(zx_machine_pkg::joy_state_t j);
		return {j.left, j.right, j.down, j.up, j.fire};
	endfunction

	// Keys 1..5 on bits 0..4
	function automatic logic [4:0] sinclair2_keys(zx_machine_pkg::joy_state_t j);
		return {j.fire, j.up, j.down, j.right, j.left};
	endfunction

	// Cursor 6/7/8 plus 0 for fire, left is on the other row
	function automatic logic [4:0] cursor_keys(zx_machine_pkg::joy_state_t j);
		return {j.down, j.up, j.right, 1'b0, j.fire};
	endfunction

	logic                       kempston_sel;
	logic [4:0]                 keys_a;
	logic [4:0]                 keys_b;
	logic [4:0]                 joy_mask;
	zx_machine_pkg::joy_state_t joy_any;
	zx_bus_pkg::bus_data_t      kempston_val;

	//==================================================================
	// Output port
	//==================================================================
	always_ff @(posedge clk_sys) begin
		if (reset) begin
			border <= `ZX_BORDER_RESET;
			ear    <= 1'b0;
			mic    <= 1'b0;
		end else if (io.io_wr & ~io.addr[0]) begin
			border <= io.wdata[2:0];
			ear    <= io.wdata[4];
			mic    <= io.wdata[3];
		end
	end

	//==================================================================
	// Joystick to key mapping
	//==================================================================
	// keys_a on row 6..0 (A12 low), keys_b on row 1..5 (A11 low)
	always_comb begin
		keys_a = '0;
		keys_b = '0;
		case (joy_mode)
			zx_machine_pkg::sinclair1: begin
				keys_a = sinclair1_keys(joy_0) | sinclair1_keys(joy_1);
			end
			zx_machine_pkg::sinclair2: begin
				keys_b = sinclair2_keys(joy_0) | sinclair2_keys(joy_1);
			end
			zx_machine_pkg::sinclair_both: begin
				keys_a = sinclair1_keys(joy_0);
				keys_b = sinclair2_keys(joy_1);
			end
			zx_machine_pkg::cursor: begin
				keys_a = cursor_keys(joy_0) | cursor_keys(joy_1);
				keys_b = {joy_0.left | joy_1.left, 4'b0000};
			end
			default: begin
			end
		endcase
	end

	assign joy_mask = ({5{io.addr[12]}} | ~keys_a) & ({5{io.addr[11]}} | ~keys_b);

	//==================================================================
	// Read values
	//==================================================================
	assign joy_any      = joy_0 | joy_1;
	assign kempston_val = (joy_mode == zx_machine_pkg::kempston) ? {3'b000, joy_any} : '0;
	assign kempston_sel = (io.addr[5:0] == `ZX_KEMPSTON_PORT);

	assign ula_hit   = io.io_rd & (kempston_sel | ~io.addr[0]);
	assign ula_rdata = kempston_sel ? kempston_val : {3'b111, key_cols & joy_mask};

endmodule

`default_nettype wire

// File: zx_io_core.sv
//====================================================================
// Paging and I/O port core of a ZX Spectrum-family machine
// Wishbone classic slave, ack one clock after each request
// model is sampled during reset only
//====================================================================
`timescale 1ns/1ns
`default_nettype none

module zx_io_core (
	input  logic                           clk_sys,
	input  logic                           reset,
	input  logic                           wb_cyc,
	input  logic                           wb_stb,
	input  logic                           wb_we,
	input  zx_bus_pkg::cycle_kind_e        wb_tga_kind,
	input  zx_bus_pkg::bus_addr_t          wb_adr,
	input  zx_bus_pkg::bus_data_t          wb_dat_w,
	output zx_bus_pkg::bus_data_t          wb_dat_r,
	output logic                           wb_ack,
	input  zx_machine_pkg::machine_model_e model,
	input  zx_machine_pkg::joy_mode_e      joy_mode,
	input  zx_machine_pkg::joy_state_t     joy_0,
	input  zx_machine_pkg::joy_state_t     joy_1,
	input  logic [4:0]                     key_cols,
	output zx_machine_pkg::phys_addr_t     phys_addr,
	output logic                           mem_wr_ok,
	output logic [2:0]                     border,
	output logic                           ear,
	output logic                           mic
);

	logic                  page_hit;
	zx_bus_pkg::bus_data_t page_rdata;
	logic                  ula_hit;
	zx_bus_pkg::bus_data_t ula_rdata;
	logic                  mem_cycle;

	zx_io_if io_bus ();

	zx_bus_slave i_bus_slave (
		.clk_sys     (clk_sys),
		.reset       (reset),
		.wb_cyc      (wb_cyc),
		.wb_stb      (wb_stb),
		.wb_we       (wb_we),
		.wb_tga_kind (wb_tga_kind),
		.wb_adr      (wb_adr),
		.wb_dat_w    (wb_dat_w),
		.wb_dat_r    (wb_dat_r),
		.wb_ack      (wb_ack),
		.io          (io_bus.bus),
		.page_hit    (page_hit),
		.page_rdata  (page_rdata),
		.ula_hit     (ula_hit),
		.ula_rdata   (ula_rdata),
		.mem_cycle   (mem_cycle)
	);

	zx_paging i_paging (
		.clk_sys    (clk_sys),
		.reset      (reset),
		.io         (io_bus.port),
		.model      (model),
		.mem_addr   (wb_adr),
		.mem_cycle  (mem_cycle),
		.phys_addr  (phys_addr),
		.mem_wr_ok  (mem_wr_ok),
		.page_hit   (page_hit),
		.page_rdata (page_rdata)
	);

	zx_ula_port i_ula_port (
		.clk_sys   (clk_sys),
		.reset     (reset),
		.io        (io_bus.port),
		.joy_mode  (joy_mode),
		.joy_0     (joy_0),
		.joy_1     (joy_1),
		.key_cols  (key_cols),
		.border    (border),
		.ear       (ear),
		.mic       (mic),
		.ula_hit   (ula_hit),
		.ula_rdata (ula_rdata)
	);

endmodule

`default_nettype wire

// File: tb_zx_io_core.sv
//====================================================================
// Testbench for the paging and I/O port core
// Vectors come from zx_test_input.txt, run from the project root
// Each bus cycle expects ack exactly one clock after the request
// Outputs are sampled on the falling edge, inputs driven on the rising
//====================================================================
`timescale 1ns/1ns
`default_nettype none

module tb_zx_io_core;

	logic                           clk_sys;
	logic                           reset;
	logic                           wb_cyc;
	logic                           wb_stb;
	logic                           wb_we;
	zx_bus_pkg::cycle_kind_e        wb_tga_kind;
	zx_bus_pkg::bus_addr_t          wb_adr;
	zx_bus_pkg::bus_data_t          wb_dat_w;
	zx_bus_pkg::bus_data_t          wb_dat_r;
	logic                           wb_ack;
	zx_machine_pkg::machine_model_e model;
	zx_machine_pkg::joy_mode_e      joy_mode;
	zx_machine_pkg::joy_state_t     joy_0;
	zx_machine_pkg::joy_state_t     joy_1;
	logic [4:0]                     key_cols;
	zx_machine_pkg::phys_addr_t     phys_addr;
	logic                           mem_wr_ok;
	logic [2:0]                     border;
	logic                           ear;
	logic                           mic;

	int errors;
	int cycles;
	int cycle_limit;

	// One entry per vector line
	int op_q[$];
	int kind_q[$];
	int addr_q[$];
	int data_q[$];
	int exp_q[$];

	// Captured in the ack cycle
	zx_bus_pkg::bus_data_t      rd_data;
	zx_machine_pkg::phys_addr_t rd_phys;
	logic                       rd_wr_ok;

	// Captured one clock after ack, with the bus idle
	zx_machine_pkg::phys_addr_t hold_phys;
	logic                       hold_wr_ok;

	zx_io_core i_zx_io_core (
		.clk_sys     (clk_sys),
		.reset       (reset),
		.wb_cyc      (wb_cyc),
		.wb_stb      (wb_stb),
		.wb_we       (wb_we),
		.wb_tga_kind (wb_tga_kind),
		.wb_adr      (wb_adr),
		.wb_dat_w    (wb_dat_w),
		.wb_dat_r    (wb_dat_r),
		.wb_ack      (wb_ack),
		.model       (model),
		.joy_mode    (joy_mode),
		.joy_0       (joy_0),
		.joy_1       (joy_1),
		.key_cols    (key_cols),
		.phys_addr   (phys_addr),
		.mem_wr_ok   (mem_wr_ok),
		.border      (border),
		.ear         (ear),
		.mic         (mic)
	);

	always #5 clk_sys = ~clk_sys;

	// Watchdog, limit set once the vectors are loaded
	always @(posedge clk_sys) begin
		cycles <= cycles + 1;
		if (cycle_limit > 0 && cycles >= cycle_limit) begin
			$display("Run stopped after %0d cycles before all vectors were done", cycles);
			$display("test failed");
			$finish;
		end
	end

	//==================================================================
	// Compare tasks
	//==================================================================
	task automatic check_byte(input string name, input zx_bus_pkg::bus_data_t exp,
		input zx_bus_pkg::bus_data_t got);
		if (got !== exp) begin
			$display("ERROR at %0t: %s expected %h, got %h", $time, name, exp, got);
			errors++;
		end
	endtask

	task automatic check_phys(input string name, input zx_machine_pkg::phys_addr_t exp,
		input zx_machine_pkg::phys_addr_t got);
		if (got !== exp) begin
			$display("ERROR at %0t: %s expected %h, got %h", $time, name, exp, got);
			errors++;
		end
	endtask

	task automatic check_flag(input string name, input logic exp, input logic got);
		if (got !== exp) begin
			$display("ERROR at %0t: %s expected %b, got %b", $time, name, exp, got);
			errors++;
		end
	endtask

	task automatic check_border(input string name, input logic [2:0] exp,
		input logic [2:0] got);
		if (got !== exp) begin
			$display("ERROR at %0t: %s expected %h, got %h", $time, name, exp, got);
			errors++;
		end
	endtask

	//==================================================================
	// Vector file and bus driving
	//==================================================================
	task automatic load_vectors();
		int    fd;
		int    n;
		int    op;
		int    kind;
		int    addr;
		int    data;
		int    exp;
		string line;
		fd = $fopen("zx_test_input.txt", "r");
		if (fd == 0) begin
			$display("Could not open the vector file zx_test_input.txt");
			errors++;
			return;
		end
		while (!$feof(fd)) begin
			line = "";
			n = $fgets(line, fd);
			if (n == 0 || line.len() == 0 || line[0] == "#") begin
				continue;
			end
			if ($sscanf(line, "%h %h %h %h %h", op, kind, addr, data, exp) == 5) begin
				op_q.push_back(op);
				kind_q.push_back(kind);
				addr_q.push_back(addr);
				data_q.push_back(data);
				exp_q.push_back(exp);
			end
		end
		$fclose(fd);
	endtask

	// Model is sampled on the three reset edges
	task automatic apply_reset(input zx_machine_pkg::machine_model_e m);
		@(posedge clk_sys);
		reset <= 1'b1;
		model <= m;
		repeat (3) @(posedge clk_sys);
		reset <= 1'b0;
	endtask

	task automatic bus_cycle(input logic we, input zx_bus_pkg::cycle_kind_e kind,
		input zx_bus_pkg::bus_addr_t addr, input zx_bus_pkg::bus_data_t data);
		int waits;
		waits = 0;
		@(posedge clk_sys);
		wb_cyc      <= 1'b1;
		wb_stb      <= 1'b1;
		wb_we       <= we;
		wb_tga_kind <= kind;
		wb_adr      <= addr;
		wb_dat_w    <= data;
		@(negedge clk_sys);
		while (!wb_ack) begin
			waits++;
			@(negedge clk_sys);
		end
		if (waits != 1) begin
			$display("At %0t ack came %0d clocks after the request at %h instead of 1",
				$time, waits, addr);
			errors++;
		end
		rd_data  = wb_dat_r;
		rd_phys  = phys_addr;
		rd_wr_ok = mem_wr_ok;
		// Drop stb for at least one clock, idle address away from the cycle's own
		@(posedge clk_sys);
		wb_cyc <= 1'b0;
		wb_stb <= 1'b0;
		wb_we  <= 1'b0;
		wb_adr <= ~addr;
		@(negedge clk_sys);
		if (wb_ack) begin
			$display("At %0t ack stayed high for more than one clock after the request at %h",
				$time, addr);
			errors++;
		end
		hold_phys  = phys_addr;
		hold_wr_ok = mem_wr_ok;
	endtask

	//==================================================================
	// Main sequence
	//==================================================================
	initial begin
		int          v_op;
		logic [31:0] v_kind;
		logic [31:0] v_addr;
		logic [31:0] v_data;
		logic [31:0] v_exp;
		clk_sys     = 1'b0;
		reset       = 1'b1;
		wb_cyc      = 1'b0;
		wb_stb      = 1'b0;
		wb_we       = 1'b0;
		wb_tga_kind = zx_bus_pkg::cycle_mem;
		wb_adr      = '0;
		wb_dat_w    = '0;
		model       = zx_machine_pkg::zx128;
		joy_mode    = zx_machine_pkg::kempston;
		joy_0       = '0;
		joy_1       = '0;
		key_cols    = 5'h1F;
		errors      = 0;
		cycles      = 0;
		cycle_limit = 0;

		load_vectors();
		if (op_q.size() == 0) begin
			$display("The vector file holds no usable vectors");
			errors++;
		end
		cycle_limit = op_q.size() * 4 + 50;

		for (int i = 0; i < op_q.size(); i++) begin
			v_op   = op_q[i];
			v_kind = kind_q[i];
			v_addr = addr_q[i];
			v_data = data_q[i];
			v_exp  = exp_q[i];
			case (v_op)
				0: apply_reset(zx_machine_pkg::machine_model_e'(v_data[1:0]));
				1: bus_cycle(1'b1, zx_bus_pkg::cycle_kind_e'(v_kind[0]), v_addr[15:0],
					v_data[7:0]);
				2: begin
					bus_cycle(1'b0, zx_bus_pkg::cycle_kind_e'(v_kind[0]), v_addr[15:0], 8'h00);
					check_byte("wb_dat_r", v_exp[7:0], rd_data);
				end
				3: begin
					bus_cycle(1'b0, zx_bus_pkg::cycle_mem, v_addr[15:0], 8'h00);
					check_byte("wb_dat_r", 8'h00, rd_data);
					check_phys("phys_addr", zx_machine_pkg::phys_addr_t'(v_exp[20:0]), rd_phys);
					check_flag("mem_wr_ok", v_data[0], rd_wr_ok);
					// Translation holds after the memory cycle
					check_phys("phys_addr", zx_machine_pkg::phys_addr_t'(v_exp[20:0]),
						hold_phys);
					check_flag("mem_wr_ok", v_data[0], hold_wr_ok);
				end
				4: begin
					@(negedge clk_sys);
					check_border("border", v_exp[2:0], border);
					check_flag("ear", v_exp[4], ear);
					check_flag("mic", v_exp[3], mic);
				end
				5: begin
					@(posedge clk_sys);
					joy_mode <= zx_machine_pkg::joy_mode_e'(v_kind[2:0]);
					joy_0    <= zx_machine_pkg::joy_state_t'(v_addr[4:0]);
					joy_1    <= zx_machine_pkg::joy_state_t'(v_addr[9:5]);
					key_cols <= v_data[4:0];
				end
				default: begin
					$display("Vector %0d has unknown operation %0d", i, v_op);
					errors++;
				end
			endcase
		end

		$display("Done: %0d vectors, %0d errors", op_q.size(), errors);
		if (errors == 0) begin
			$display("test passed");
		end else begin
			$display("test failed");
		end
		$finish;
	end

endmodule

`default_nettype wire

// File: zx_test_input.txt
# columns (hex): op kind addr data expect; op 0 reset model=data, 1 write, 2 read byte, 3 mem probe
# (data=mem_wr_ok, expect=phys_addr), 4 expect={ear,mic,border}, 5 joy_mode=kind addr={joy_1,joy_0} data=key_cols
# 128K: ack timing and idle ports
0 0 0000 01 0
2 1 00FF 00 FF
2 1 FFFF 00 FF
2 1 7FFD 00 FF
# 128K: 7FFD paging and lock
3 0 0000 0 100000
3 0 4123 1 14123
3 0 8000 1 08000
3 0 C010 1 00010
1 1 7FFD 13 0
3 0 C010 1 0C010
3 0 0005 0 104005
1 1 7FFD 26 0
3 0 C000 1 18000
3 0 0000 0 100000
1 1 7FFD 01 0
3 0 C000 1 18000
# 48K: 7FFD ignored
0 0 0000 00 0
1 1 7FFD 17 0
3 0 C000 1 00000
3 0 0000 0 10C000
# Pentagon 1024: extension bits and lock rule
0 0 0000 02 0
1 1 7FFD E5 0
3 0 C000 1 F4000
1 1 7FFD 42 0
3 0 C000 1 28000
1 1 EFF7 04 0
1 1 7FFD 23 0
3 0 C000 1 2C000
1 1 7FFD 07 0
3 0 C000 1 2C000
1 1 EFF7 00 0
1 1 7FFD 07 0
3 0 C000 1 1C000
3 0 0000 0 100000
# +3: readback, ROM select, special modes
0 0 0000 03 0
2 1 1FFD 00 00
1 1 7FFD 14 0
2 1 1FFD 00 14
1 1 3FFD 17 0
2 1 1FFD 00 14
1 1 1FFD 04 0
3 0 0000 0 10C000
3 0 C000 1 10000
1 1 1FFD 01 0
3 0 0ABC 1 00ABC
3 0 4ABC 1 04ABC
3 0 8ABC 1 08ABC
3 0 CABC 1 0CABC
1 1 1FFD 03 0
3 0 0ABC 1 10ABC
3 0 4ABC 1 14ABC
3 0 8ABC 1 18ABC
3 0 CABC 1 1CABC
1 1 1FFD 05 0
3 0 0ABC 1 10ABC
3 0 4ABC 1 14ABC
3 0 8ABC 1 18ABC
3 0 CABC 1 0CABC
1 1 1FFD 07 0
3 0 0ABC 1 10ABC
3 0 4ABC 1 1CABC
3 0 8ABC 1 18ABC
3 0 CABC 1 0CABC
1 1 7FFD 20 0
2 1 1FFD 00 20
1 1 1FFD 00 0
3 0 0ABC 1 10ABC
# ULA output port
4 0 0000 00 00
1 1 00FE 15 0
4 0 0000 00 15
1 1 FFFE 0A 0
4 0 0000 00 0A
1 1 00FF 07 0
4 0 0000 00 0A
# Kempston
5 0 0111 1F 0
2 1 001F 00 19
2 1 EFFE 00 FF
5 0 0111 1B 0
2 1 FEFE 00 FB
# Sinclair I
5 1 0058 1F 0
2 1 EFFE 00 EC
2 1 F7FE 00 FF
2 1 001F 00 00
# Sinclair II
5 2 0005 1F 0
2 1 F7FE 00 F9
2 1 EFFE 00 FF
# Both Sinclair
5 3 0210 1F 0
2 1 EFFE 00 FE
2 1 F7FE 00 EF
2 1 E7FE 00 EE
# Cursor
5 4 0026 1E 0
2 1 EFFE 00 EA
2 1 F7FE 00 EE
2 1 00FF 00 FF

// File: project.f
+incdir+.
zx_bus_pkg.sv
zx_machine_pkg.sv
zx_io_if.sv
zx_bus_slave.sv
zx_paging.sv
zx_ula_port.sv
zx_io_core.sv
tb_zx_io_core.sv

// File: Bender.yml
package:
  name: zx_io_core

sources:
  - include_dirs:
      - .
    files:
      - zx_bus_pkg.sv
      - zx_machine_pkg.sv
      - zx_io_if.sv
      - zx_bus_slave.sv
      - zx_paging.sv
      - zx_ula_port.sv
      - zx_io_core.sv
  - target: test
    files:
      - tb_zx_io_core.sv
